//--- design/trackball_pkg.sv
// Trackball shared sizes, stick and bank types, read opcode enum and reset seed table
package trackball_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int NUM_AXES   = 8;                 // Four sticks with X and Y each
    localparam int AXIS_W     = 12;                // Position counter width
    localparam int STICK_W    = 8;                 // Signed analog reading width
    localparam int STEP_SHIFT = 3;                 // Reading divided by eight per update
    localparam int IDX_W      = $clog2(NUM_AXES);  // Axis index width

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [AXIS_W-1:0] axis_t;             // Position or step, modulo 4096
    typedef logic [IDX_W-1:0]  axis_idx_t;         // Even is X, odd is Y

    typedef struct packed {
        logic signed [STICK_W-1:0] y;              // Vertical reading
        logic signed [STICK_W-1:0] x;              // Horizontal reading
    } stick_t;

    typedef struct packed {
        stick_t stick1;                            // Player 1 primary
        stick_t stick1_alt;                        // Player 1 alternate source
        stick_t stick2;                            // Player 2 primary
        stick_t stick2_alt;                        // Player 2 alternate source
        stick_t stick3;
        stick_t stick4;
    } analog_in_t;

    typedef axis_t [NUM_AXES-1:0] step_bank_t;     // One signed step per axis
    typedef axis_t [NUM_AXES-1:0] axis_bank_t;     // One position per axis

    // CPU read opcodes
    typedef enum logic [1:0] {
        RD_NONE,                                   // No access this cycle
        RD_LO,                                     // Low byte and nibble capture
        RD_HI                                      // Captured high nibble
    } rd_op_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reset positions
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Nibble i+1 over 0A+i, low nibble wraps past F to 1
    localparam axis_bank_t AXIS_SEED = {
        12'h802,                                   // Axis 7
        12'h701,                                   // Axis 6
        12'h60f,
        12'h50e,
        12'h40d,
        12'h30c,
        12'h20b,
        12'h10a                                    // Axis 0
    };

endpackage

//--- design/trackball_line_ctrl.sv
// Trackball control with blank edge detect, line divider and CPU read decode
`timescale 1ns/100ps

module trackball_line_ctrl #(
    parameter int LINE_DIV = 64                    // Lines per position update
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       lhbl,       // Horizontal blank, active low
    input  logic                       cpu_rd,     // Read strobe
    input  logic [3:0]                 cpu_addr,   // Axis in 3:1, byte in 0
    output logic                       update,     // One-cycle step strobe
    output trackball_pkg::rd_op_e      rd_op,
    output trackball_pkg::axis_idx_t   rd_axis
);

    localparam int             CNT_W    = (LINE_DIV > 1) ? $clog2(LINE_DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(LINE_DIV - 1);

    logic             lhbl_l;                      // Previous lhbl sample
    logic             lhbl_fall;
    logic [CNT_W-1:0] line_cnt;                    // Lines since last update

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Blank edge and line divider
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign lhbl_fall = lhbl_l & ~lhbl;             // High last edge, low now
    assign update    = lhbl_fall && (line_cnt == '0);  // Counted edge

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lhbl_l   <= 1'b0;                      // Low blank after reset is no edge
            line_cnt <= '0;                        // First edge updates
        end else begin
            lhbl_l <= lhbl;
            if (lhbl_fall) begin
                if (line_cnt == CNT_LAST) begin
                    line_cnt <= '0;                // Wrap modulo LINE_DIV
                end else begin
                    line_cnt <= line_cnt + 1'b1;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // CPU read decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        rd_axis = cpu_addr[3:1];                   // Axis select
        if (!cpu_rd) begin
            rd_op = trackball_pkg::RD_NONE;
        end else if (cpu_addr[0]) begin
            rd_op = trackball_pkg::RD_HI;          // Odd address is high byte
        end else begin
            rd_op = trackball_pkg::RD_LO;
        end
    end

endmodule

//--- design/trackball_stick_sel.sv
// Trackball stick source select and scaling of readings into 12-bit steps
`timescale 1ns/100ps

module trackball_stick_sel (
    input  logic                       right_en,   // Use alternate sticks 1 and 2
    input  trackball_pkg::analog_in_t  sticks,
    output trackball_pkg::step_bank_t  steps
);

    localparam int NUM_STICKS = trackball_pkg::NUM_AXES / 2;

    trackball_pkg::stick_t sel [NUM_STICKS];       // Chosen source per stick

    // Signed reading to 12-bit step, arithmetic shift keeps the sign
    function automatic trackball_pkg::axis_t scale(
        input logic signed [trackball_pkg::STICK_W-1:0] v
    );
        logic signed [trackball_pkg::AXIS_W-1:0] ext;
        ext   = v;                                 // Sign extend first
        scale = ext >>> trackball_pkg::STEP_SHIFT;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Source select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        sel[0] = right_en ? sticks.stick1_alt : sticks.stick1;
        sel[1] = right_en ? sticks.stick2_alt : sticks.stick2;
        sel[2] = sticks.stick3;                    // No alternate for 3 and 4
        sel[3] = sticks.stick4;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Axis mapping
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        for (int i = 0; i < NUM_STICKS; i++) begin
            steps[2*i]   = scale(sel[i].x);        // X on even axis
            steps[2*i+1] = scale(sel[i].y);        // Y on odd axis
        end
    end

endmodule

//--- design/trackball_accum.sv
// Trackball position counters with reset seeds, stepped on the update strobe
`timescale 1ns/100ps

module trackball_accum (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       update,     // Step all axes this cycle
    input  trackball_pkg::step_bank_t  steps,      // Signed steps per axis
    output trackball_pkg::axis_bank_t  positions
);

    trackball_pkg::axis_bank_t pos_q;              // Counter bank
    trackball_pkg::axis_bank_t pos_d;              // Next positions

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Next position
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        for (int i = 0; i < trackball_pkg::NUM_AXES; i++) begin
            if (i % 2 == 0) begin
                pos_d[i] = pos_q[i] - steps[i];    // X moves against the stick
            end else begin
                pos_d[i] = pos_q[i] + steps[i];    // Y follows the stick
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Counter registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pos_q <= trackball_pkg::AXIS_SEED;     // Known start positions
        end else if (update) begin
            pos_q <= pos_d;                        // Wraps modulo 4096
        end
    end

    assign positions = pos_q;

endmodule

//--- design/trackball_read_port.sv
// Trackball CPU byte read mux with high nibble latch and registered data out
`timescale 1ns/100ps

module trackball_read_port (
    input  logic                       clk,
    input  logic                       rst,
    input  trackball_pkg::rd_op_e      rd_op,      // Decoded read
    input  trackball_pkg::axis_idx_t   rd_axis,    // Selected counter
    input  trackball_pkg::axis_bank_t  positions,
    output logic [7:0]                 cpu_dout    // Held until next read
);

    localparam int HI_W = trackball_pkg::AXIS_W - 8;  // Upper nibble width

    trackball_pkg::axis_t sel_pos;                 // Addressed counter
    logic [HI_W-1:0]      hi_nib;                  // Captured on low byte read

    assign sel_pos = positions[rd_axis];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Data register and nibble latch
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_dout <= 8'h00;
            hi_nib   <= '0;
        end else begin
            case (rd_op)
                trackball_pkg::RD_LO: begin
                    cpu_dout <= sel_pos[7:0];      // Value before any same-cycle update
                    hi_nib   <= sel_pos[trackball_pkg::AXIS_W-1:8];
                end
                trackball_pkg::RD_HI: begin
                    // Latched nibble keeps the byte pair coherent
                    cpu_dout <= {{(8 - HI_W){1'b0}}, hi_nib};
                end
                default: begin
                    cpu_dout <= cpu_dout;          // Hold last value
                end
            endcase
        end
    end

endmodule

//--- design/trackball_io.sv
// Trackball emulation top level joining control, stick select, counters and CPU read port
`timescale 1ns/100ps

module trackball_io #(
    parameter int LINE_DIV = 64                    // Lines between updates
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       lhbl,       // Horizontal blank, active low
    input  logic                       right_en,   // Alternate stick select
    input  trackball_pkg::analog_in_t  sticks,
    input  logic                       cpu_rd,
    input  logic [3:0]                 cpu_addr,   // Axis in 3:1, byte in 0
    output logic [7:0]                 cpu_dout
);

    logic                       update;            // Counted blank edge
    trackball_pkg::rd_op_e      rd_op;
    trackball_pkg::axis_idx_t   rd_axis;
    trackball_pkg::step_bank_t  steps;             // Scaled readings
    trackball_pkg::axis_bank_t  positions;         // Counter bank

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    trackball_line_ctrl #(
        .LINE_DIV (LINE_DIV)
    ) u_line_ctrl (
        .clk      (clk),
        .rst      (rst),
        .lhbl     (lhbl),
        .cpu_rd   (cpu_rd),
        .cpu_addr (cpu_addr),
        .update   (update),
        .rd_op    (rd_op),
        .rd_axis  (rd_axis)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    trackball_stick_sel u_stick_sel (
        .right_en (right_en),
        .sticks   (sticks),
        .steps    (steps)
    );

    trackball_accum u_accum (
        .clk       (clk),
        .rst       (rst),
        .update    (update),
        .steps     (steps),
        .positions (positions)
    );

    trackball_read_port u_read_port (
        .clk       (clk),
        .rst       (rst),
        .rd_op     (rd_op),
        .rd_axis   (rd_axis),
        .positions (positions),
        .cpu_dout  (cpu_dout)
    );

endmodule

//--- test/tb_trackball_io.sv
// Trackball testbench with reference model, compare tasks, LCG stimulus, timeout and directed tests
`timescale 1ns/100ps

module tb_trackball_io;

    localparam int LINE_DIV   = 64;                // Lines per update in the DUT
    localparam int MAX_CYCLES = 40000;             // Run limit in clock cycles

    logic                      clk;
    logic                      rst;
    logic                      lhbl;
    logic                      right_en;
    trackball_pkg::analog_in_t sticks;
    logic                      cpu_rd;
    logic [3:0]                cpu_addr;
    logic [7:0]                cpu_dout;

    trackball_pkg::axis_t model_pos [trackball_pkg::NUM_AXES];  // Expected positions
    int                   edge_cnt;                // Model line count
    logic                 last_updated;            // Last line was an update edge
    logic [31:0]          lcg_state;
    int                   cycles;

    trackball_io #(
        .LINE_DIV (LINE_DIV)
    ) DUT (
        .clk      (clk),
        .rst      (rst),
        .lhbl     (lhbl),
        .right_en (right_en),
        .sticks   (sticks),
        .cpu_rd   (cpu_rd),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                     // 10 ns period
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Failure and compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_byte(input string name, input logic [7:0] act, input logic [7:0] exp);
        if (act !== exp) begin
            abort_run($sformatf("FAILED at %0t ns: %s expected 0x%02h, got 0x%02h",
                                $time, name, exp, act));
        end
    endtask

    task automatic check_axis(input string name, input trackball_pkg::axis_t act,
                              input trackball_pkg::axis_t exp);
        if (act !== exp) begin
            abort_run($sformatf("FAILED at %0t ns: %s expected 0x%03h, got 0x%03h",
                                $time, name, exp, act));
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            abort_run($sformatf("Timeout: no result after %0d clock cycles", MAX_CYCLES));
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [7:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:23];                   // Next byte from the high state bits
    endfunction

    // Floor of reading over eight, wrapped to 12 bits
    function automatic trackball_pkg::axis_t step_from_reading(input logic signed [7:0] r);
        int v;
        int q;
        v = r;
        if (v >= 0) begin
            q = v / 8;
        end else begin
            q = -((-v + 7) / 8);                   // Round toward minus infinity
        end
        return trackball_pkg::axis_t'(q);
    endfunction

    function automatic logic signed [7:0] reading_of(input int axis);
        trackball_pkg::stick_t s;
        case (axis / 2)
            0:       s = right_en ? sticks.stick1_alt : sticks.stick1;
            1:       s = right_en ? sticks.stick2_alt : sticks.stick2;
            2:       s = sticks.stick3;
            default: s = sticks.stick4;
        endcase
        return (axis % 2 == 1) ? s.y : s.x;        // Odd axis is Y
    endfunction

    task automatic seed_model();
        int lo_nib;
        for (int i = 0; i < trackball_pkg::NUM_AXES; i++) begin
            lo_nib = (10 + i > 15) ? 10 + i - 15 : 10 + i;  // Skips zero on wrap
            model_pos[i] = {4'(i + 1), 4'h0, 4'(lo_nib)};
        end
        edge_cnt = 0;
    endtask

    // One falling edge of lhbl, held low for low_cycles clocks
    task automatic hblank_line(input int low_cycles);
        logic updated;
        updated = (edge_cnt == 0);
        @(posedge clk);
        lhbl <= 1'b0;
        repeat (low_cycles) @(posedge clk);
        lhbl <= 1'b1;
        if (updated) begin
            for (int i = 0; i < trackball_pkg::NUM_AXES; i++) begin
                if (i % 2 == 0) begin
                    model_pos[i] = model_pos[i] - step_from_reading(reading_of(i));
                end else begin
                    model_pos[i] = model_pos[i] + step_from_reading(reading_of(i));
                end
            end
        end
        last_updated = updated;
        edge_cnt     = (edge_cnt + 1) % LINE_DIV;
    endtask

    task automatic advance_update();
        do begin
            hblank_line(1);
        end while (!last_updated);                 // Stop on the counted edge
    endtask

    task automatic set_inputs(input trackball_pkg::analog_in_t v, input logic sel);
        @(posedge clk);
        sticks   <= v;
        right_en <= sel;
    endtask

    task automatic cpu_read(input logic [3:0] addr, output logic [7:0] data);
        @(posedge clk);
        cpu_rd   <= 1'b1;
        cpu_addr <= addr;
        @(posedge clk);                            // DUT loads cpu_dout here
        cpu_rd   <= 1'b0;
        @(negedge clk);
        data = cpu_dout;
    endtask

    task automatic verify_axis(input int axis);
        logic [7:0] lo;
        logic [7:0] hi;
        cpu_read({3'(axis), 1'b0}, lo);
        cpu_read({3'(axis), 1'b1}, hi);
        check_byte($sformatf("cpu_dout high byte axis %0d", axis), hi,
                   {4'h0, model_pos[axis][11:8]});
        check_axis($sformatf("position axis %0d", axis), {hi[3:0], lo}, model_pos[axis]);
    endtask

    task automatic verify_all();
        for (int i = 0; i < trackball_pkg::NUM_AXES; i++) begin
            verify_axis(i);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic test_reset_values();
        @(negedge clk);
        check_byte("cpu_dout after reset", cpu_dout, 8'h00);  // Data register cleared
        verify_all();                              // Seeds straight after reset
    endtask

    task automatic test_update_rate();
        trackball_pkg::analog_in_t v;
        v = 96'h40C0_3070_90A0_2858_B848_D818;     // Every step non-zero
        set_inputs(v, 1'b0);
        hblank_line(1);                            // First edge moves all axes
        verify_all();
        hblank_line(20);                           // Long low counts once
        repeat (10) @(posedge clk);                // High level alone does nothing
        verify_all();
        repeat (62) hblank_line(1);
        verify_all();
        hblank_line(1);                            // 64th edge after the first
        verify_all();
    endtask

    task automatic test_steps();
        logic [$bits(trackball_pkg::analog_in_t)-1:0] raw;
        trackball_pkg::analog_in_t v;
        repeat (12) begin
            for (int k = 0; k < 12; k++) begin
                raw[8*k +: 8] = lcg_next();
            end
            v = raw;
            set_inputs(v, 1'b0);
            advance_update();
            verify_all();
        end
        v = {6{16'h807F}};                         // Y at -128, X at +127
        set_inputs(v, 1'b0);
        repeat (48) begin
            advance_update();                      // Axes 0 and 1 pass through zero
            verify_axis(0);
            verify_axis(1);
        end
        verify_all();
    endtask

    task automatic test_source_select();
        trackball_pkg::analog_in_t v;
        v.stick1     = 16'h7F7F;
        v.stick1_alt = 16'hE038;
        v.stick2     = 16'h8080;
        v.stick2_alt = 16'h20D0;
        v.stick3     = 16'h1CF0;
        v.stick4     = 16'hC444;
        set_inputs(v, 1'b1);                       // Alternates for sticks 1 and 2
        advance_update();
        verify_all();
        set_inputs(v, 1'b0);                       // Back to primaries
        advance_update();
        verify_all();
    endtask

    task automatic test_read_coherence();
        trackball_pkg::analog_in_t v;
        trackball_pkg::axis_t      old_pos;
        trackball_pkg::axis_t      nxt;
        logic [7:0]                lo;
        logic [7:0]                hi;
        v          = '0;
        v.stick2.y = 8'sh7F;                       // Only axis 3 moves
        set_inputs(v, 1'b0);
        nxt = model_pos[3] + step_from_reading(8'sh7F);
        while (nxt[11:8] == model_pos[3][11:8]) begin
            advance_update();                      // Creep up to a nibble boundary
            nxt = model_pos[3] + step_from_reading(8'sh7F);
        end
        old_pos = model_pos[3];
        cpu_read(4'h6, lo);
        check_byte("cpu_dout low byte axis 3", lo, old_pos[7:0]);
        advance_update();                          // Carries into the high nibble
        cpu_read(4'h7, hi);
        check_byte("cpu_dout high byte axis 3", hi, {4'h0, old_pos[11:8]});
        verify_axis(3);                            // Fresh pair sees the new value
    endtask

    initial begin
        rst       = 1'b1;
        lhbl      = 1'b1;
        right_en  = 1'b0;
        sticks    = '0;
        cpu_rd    = 1'b0;
        cpu_addr  = 4'h0;
        cycles    = 0;
        lcg_state = 32'd96;
        seed_model();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        test_reset_values();
        test_update_rate();
        test_steps();
        test_source_select();
        test_read_coherence();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- tb.f
design/trackball_pkg.sv
design/trackball_line_ctrl.sv
design/trackball_stick_sel.sv
design/trackball_accum.sv
design/trackball_read_port.sv
design/trackball_io.sv
test/tb_trackball_io.sv

//--- Bender.yml
package:
  name: trackball_io

sources:
  # Design sources in compile order
  - files:
      - design/trackball_pkg.sv
      - design/trackball_line_ctrl.sv
      - design/trackball_stick_sel.sv
      - design/trackball_accum.sv
      - design/trackball_read_port.sv
      - design/trackball_io.sv

  # Testbench
  - target: test
    files:
      - test/tb_trackball_io.sv
